// ==== common/beam_pkg.sv ====
package beam_pkg;

    // stream geometry
    localparam int num_channels = 4;
    localparam int num_samples = 8;

    // input and output samples share one width
    localparam int sample_width = 16;

    // weights are Q1.7, so one sign bit and seven fraction bits
    localparam int weight_width = 8;
    localparam int weight_frac_bits = 7;

    // 16x8 signed product is 24 bits, one more for the add or subtract
    localparam int product_width = 25;

    // four 16-bit terms need two extra bits of headroom
    localparam int sum_width = 18;

    // divide the channel sum by num_channels
    localparam int sum_shift = 2;

    typedef logic signed [sample_width-1:0] sample_t;

    // full-width complex product-sum of one sample
    typedef logic signed [product_width-1:0] product_t;

    // cross-channel accumulator
    typedef logic signed [sum_width-1:0] sum_t;

    // eight complex samples, real and imag parts in separate lanes
    typedef struct packed {
        sample_t [num_samples-1:0] re;
        sample_t [num_samples-1:0] im;
    } cplx_vec_t;

    // one complex weight
    typedef struct packed {
        logic signed [weight_width-1:0] re;
        logic signed [weight_width-1:0] im;
    } weight_t;

    // one input beat, all channels arrive together
    typedef struct packed {
        cplx_vec_t [num_channels-1:0] chan;
        logic last;
    } beam_beat_t;

    // weight per channel, index matches beam_beat_t.chan
    typedef weight_t [num_channels-1:0] weight_set_t;

endpackage

// ==== hw/beam_ingress.sv ====
module beam_ingress (
    input  logic clock,
    input  logic resetn,

    // pipeline may move this cycle
    input  logic advance,

    // input stream
    input  logic s_valid,
    output logic s_ready,
    input  beam_pkg::beam_beat_t s_beat,
    input  beam_pkg::weight_set_t weights,

    // stage one towards the weighting blocks and combiner
    output logic stage_valid,
    output beam_pkg::beam_beat_t stage_beat,
    output beam_pkg::weight_set_t stage_weights
);

    // ready whenever the whole pipeline can shift
    assign s_ready = advance;

    // stage one valid
    // a bubble is loaded when s_valid is low, so the beat transfers exactly on s_valid && advance
    always_ff @(posedge clock) begin
        if (!resetn) begin
            stage_valid <= 1'b0;
        end else if (advance) begin
            stage_valid <= s_valid;
        end
    end

    // beat and its weights are captured on the same edge
    // each beat therefore carries the weight set seen when it was accepted
    always_ff @(posedge clock) begin
        if (advance) begin
            stage_beat <= s_beat;
            stage_weights <= weights;
        end
    end

endmodule

// ==== hw/channel_weighting/channel_weighting.sv ====
module channel_weighting (
    input  logic clock,

    // shift enable shared by every stage
    input  logic advance,

    // one channel of the stage one beat
    input  beam_pkg::cplx_vec_t samples,
    input  beam_pkg::weight_t weight,

    // weighted samples, stage two
    output beam_pkg::cplx_vec_t weighted
);

    import beam_pkg::*;

    // weight parts as signed operands
    logic signed [weight_width-1:0] w_re;
    logic signed [weight_width-1:0] w_im;

    // full precision product-sums per sample
    product_t prod_re [num_samples];
    product_t prod_im [num_samples];

    // after removing the Q1.7 fraction
    product_t scaled_re [num_samples];
    product_t scaled_im [num_samples];

    assign w_re = $signed(weight.re);
    assign w_im = $signed(weight.im);

    // true complex multiply
    // (a + jb)(c + jd) = (ac - bd) + j(ad + bc), with w = a + jb
    always_comb begin
        for (int i = 0; i < num_samples; i++) begin
            // all operands signed, so they extend to 25 bits before the add
            prod_re[i] = w_re * $signed(samples.re[i]) - w_im * $signed(samples.im[i]);
            prod_im[i] = w_re * $signed(samples.im[i]) + w_im * $signed(samples.re[i]);

            // arithmetic shift keeps the sign
            scaled_re[i] = prod_re[i] >>> weight_frac_bits;
            scaled_im[i] = prod_im[i] >>> weight_frac_bits;
        end
    end

    // low 16 bits only, overflow wraps
    // data only here, valid is tracked by the combiner
    always_ff @(posedge clock) begin
        if (advance) begin
            for (int i = 0; i < num_samples; i++) begin
                weighted.re[i] <= scaled_re[i][sample_width-1:0];
                weighted.im[i] <= scaled_im[i][sample_width-1:0];
            end
        end
    end

endmodule

// ==== hw/combiner/beam_combiner.sv ====
module beam_combiner (
    input  logic clock,
    input  logic resetn,

    // stage one control from the ingress
    input  logic in_valid,
    input  logic in_last,

    // stage two data from the weighting blocks
    input  beam_pkg::cplx_vec_t [beam_pkg::num_channels-1:0] weighted,

    // shift enable for the whole pipeline
    output logic advance,

    // output stream
    output logic m_valid,
    input  logic m_ready,
    output beam_pkg::cplx_vec_t m_data,
    output logic m_last
);

    import beam_pkg::*;

    // stage two control, aligned with the weighted data
    logic valid_q;
    logic last_q;

    // per sample cross-channel sums
    sum_t sum_re [num_samples];
    sum_t sum_im [num_samples];

    // sums after the divide by num_channels
    sum_t scaled_re [num_samples];
    sum_t scaled_im [num_samples];

    // output register empty or being drained this cycle
    // all three stages stall together otherwise
    assign advance = !m_valid || m_ready;

    // add the four channels per sample and per part
    always_comb begin
        sum_t acc_re;
        sum_t acc_im;
        for (int s = 0; s < num_samples; s++) begin
            acc_re = '0;
            acc_im = '0;
            for (int c = 0; c < num_channels; c++) begin
                // sign extend each 16-bit term to 18 bits
                acc_re = acc_re + sum_t'($signed(weighted[c].re[s]));
                acc_im = acc_im + sum_t'($signed(weighted[c].im[s]));
            end
            sum_re[s] = acc_re;
            sum_im[s] = acc_im;
            scaled_re[s] = sum_re[s] >>> sum_shift;
            scaled_im[s] = sum_im[s] >>> sum_shift;
        end
    end

    // valids for stage two and the output
    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_q <= 1'b0;
            m_valid <= 1'b0;
        end else if (advance) begin
            valid_q <= in_valid;
            m_valid <= valid_q;
        end
    end

    // last follows its beat, result fits 16 bits after the shift
    always_ff @(posedge clock) begin
        if (advance) begin
            last_q <= in_last;
            m_last <= last_q;
            for (int s = 0; s < num_samples; s++) begin
                m_data.re[s] <= scaled_re[s][sample_width-1:0];
                m_data.im[s] <= scaled_im[s][sample_width-1:0];
            end
        end
    end

endmodule

// ==== hw/beam_former.sv ====
module beam_former (
    input  logic clock,
    input  logic resetn,

    // input stream, four channels per beat
    input  logic s_valid,
    output logic s_ready,
    input  beam_pkg::beam_beat_t s_beat,
    input  beam_pkg::weight_set_t weights,

    // combined output stream
    output logic m_valid,
    input  logic m_ready,
    output beam_pkg::cplx_vec_t m_data,
    output logic m_last
);

    import beam_pkg::*;

    // pipeline shift enable, decided in the combiner
    logic advance;

    // stage one
    logic stage_valid;
    beam_beat_t stage_beat;
    weight_set_t stage_weights;

    // stage two, one weighted vector per channel
    cplx_vec_t [num_channels-1:0] weighted;

    beam_ingress u_ingress (
        .clock         (clock),
        .resetn        (resetn),
        .advance       (advance),
        .s_valid       (s_valid),
        .s_ready       (s_ready),
        .s_beat        (s_beat),
        .weights       (weights),
        .stage_valid   (stage_valid),
        .stage_beat    (stage_beat),
        .stage_weights (stage_weights)
    );

    // one complex multiplier per antenna channel
    for (genvar ch = 0; ch < num_channels; ch++) begin : g_chan
        channel_weighting u_weighting (
            .clock    (clock),
            .advance  (advance),
            .samples  (stage_beat.chan[ch]),
            .weight   (stage_weights[ch]),
            .weighted (weighted[ch])
        );
    end

    // last rides with stage one valid into the combiner
    beam_combiner u_combiner (
        .clock    (clock),
        .resetn   (resetn),
        .in_valid (stage_valid),
        .in_last  (stage_beat.last),
        .weighted (weighted),
        .advance  (advance),
        .m_valid  (m_valid),
        .m_ready  (m_ready),
        .m_data   (m_data),
        .m_last   (m_last)
    );

endmodule

// ==== sim/beam_former_props.sv ====
module beam_former_props (
    input  logic clock,
    input  logic resetn,
    input  logic s_ready,
    input  logic m_valid,
    input  logic m_ready,
    input  beam_pkg::cplx_vec_t m_data,
    input  logic m_last
);

    timeunit 1ns;
    timeprecision 1ps;

    // a stalled output beat holds until it transfers
    output_hold : assert property (
        @(posedge clock) disable iff (!resetn)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_data) && $stable(m_last))
    ) else $error("output beat changed while stalled");

    // input side is ready exactly when the pipeline can shift
    ready_rule : assert property (
        @(posedge clock) disable iff (!resetn)
        s_ready == (!m_valid || m_ready)
    ) else $error("s_ready does not follow output state");

    // output stays empty while reset is held
    reset_empty : assert property (
        @(posedge clock)
        !resetn |=> !m_valid
    ) else $error("m_valid high during reset");

endmodule

bind beam_former beam_former_props u_props (
    .clock   (clock),
    .resetn  (resetn),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_last  (m_last)
);

// ==== sim/beam_former_tb.sv ====
module beam_former_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import beam_pkg::*;

    localparam int clock_period = 100;
    localparam int reset_cycles = 5;

    // random beats after the single directed beat
    localparam int num_beats = 400;
    localparam int total_beats = num_beats + 1;

    // wide margin over the two or three cycles a beat normally needs
    localparam int timeout_cycles = total_beats * 20 + reset_cycles;

    logic clock;
    logic resetn;
    logic s_valid;
    logic s_ready;
    beam_beat_t s_beat;
    weight_set_t weights;
    logic m_valid;
    logic m_ready;
    cplx_vec_t m_data;
    logic m_last;

    integer seed = 56407;
    int errors = 0;
    int beats_in = 0;
    int beats_out = 0;

    // reference results in acceptance order
    cplx_vec_t exp_data[$];
    logic exp_last[$];
    cplx_vec_t want;
    logic want_last;

    beam_former UUT (
        .clock   (clock),
        .resetn  (resetn),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_beat  (s_beat),
        .weights (weights),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_data  (m_data),
        .m_last  (m_last)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // compares one value and counts a mismatch
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error at %0t ns: %s, got %h expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    // full-scale values now and then so that products wrap
    function automatic sample_t random_sample();
        int pick;
        int r;
        pick = $random(seed) & 15;
        r = $random(seed);
        if (pick == 0)
            return sample_t'(16'h8000);
        else if (pick == 1)
            return sample_t'(16'h7fff);
        else
            return sample_t'(r[15:0]);
    endfunction

    // minus 128 is the one Q1.7 weight with no positive twin
    function automatic logic [7:0] random_weight_part();
        int pick;
        int r;
        pick = $random(seed) & 7;
        r = $random(seed);
        if (pick == 0)
            return 8'h80;
        else
            return r[7:0];
    endfunction

    function automatic beam_beat_t random_beat();
        beam_beat_t b;
        int r;
        for (int c = 0; c < num_channels; c++) begin
            for (int s = 0; s < num_samples; s++) begin
                b.chan[c].re[s] = random_sample();
                b.chan[c].im[s] = random_sample();
            end
        end
        r = $random(seed);
        b.last = r[0];
        return b;
    endfunction

    function automatic weight_set_t random_weights();
        weight_set_t w;
        for (int c = 0; c < num_channels; c++) begin
            w[c].re = random_weight_part();
            w[c].im = random_weight_part();
        end
        return w;
    endfunction

    // model of the beam output
    // per channel complex product with 7 fraction bits dropped and wrapped to 16
    // then the four channels added and divided by four
    function automatic cplx_vec_t expected_beam(input beam_beat_t b, input weight_set_t w);
        cplx_vec_t out;
        int wr;
        int wi;
        int sr;
        int si;
        int pr;
        int pi;
        int acc_re;
        int acc_im;
        logic [15:0] t_re;
        logic [15:0] t_im;
        for (int s = 0; s < num_samples; s++) begin
            acc_re = 0;
            acc_im = 0;
            for (int c = 0; c < num_channels; c++) begin
                wr = int'($signed(w[c].re));
                wi = int'($signed(w[c].im));
                sr = int'($signed(b.chan[c].re[s]));
                si = int'($signed(b.chan[c].im[s]));
                pr = (wr * sr - wi * si) >>> 7;
                pi = (wr * si + wi * sr) >>> 7;
                t_re = pr[15:0];
                t_im = pi[15:0];
                acc_re = acc_re + int'($signed(t_re));
                acc_im = acc_im + int'($signed(t_im));
            end
            acc_re = acc_re >>> 2;
            acc_im = acc_im >>> 2;
            out.re[s] = acc_re[15:0];
            out.im[s] = acc_im[15:0];
        end
        return out;
    endfunction

    // scoreboard sees the values from before each edge
    always @(posedge clock) begin
        if (resetn) begin
            if (s_valid && s_ready) begin
                exp_data.push_back(expected_beam(s_beat, weights));
                exp_last.push_back(s_beat.last);
                beats_in++;
            end
            if (m_valid && m_ready) begin
                if (exp_data.size() == 0) begin
                    $display("output beat at %0t ns arrived with no input beat pending", $time);
                    errors++;
                end else begin
                    want = exp_data.pop_front();
                    want_last = exp_last.pop_front();
                    for (int s = 0; s < num_samples; s++) begin
                        check_value($sformatf("beat %0d sample %0d re", beats_out, s),
                                    32'(m_data.re[s]), 32'(want.re[s]));
                        check_value($sformatf("beat %0d sample %0d im", beats_out, s),
                                    32'(m_data.im[s]), 32'(want.im[s]));
                    end
                    check_value($sformatf("beat %0d last", beats_out), 32'(m_last),
                                32'(want_last));
                end
                beats_out++;
            end
        end
    end

    initial begin
        int sent;
        int cycles;
        logic seen;
        logic accepted;

        resetn = 1'b0;
        s_valid = 1'b0;
        s_beat = '0;
        weights = '0;
        m_ready = 1'b0;

        repeat (reset_cycles) @(posedge clock);
        check_value("m_valid during reset", 32'(m_valid), 32'd0);
        resetn <= 1'b1;

        // empty pipeline accepts at once
        // single beat goes straight through with no back-pressure
        @(posedge clock);
        check_value("s_ready after reset", 32'(s_ready), 32'd1);
        check_value("m_valid after reset", 32'(m_valid), 32'd0);
        s_valid <= 1'b1;
        s_beat <= random_beat();
        weights <= random_weights();
        m_ready <= 1'b1;

        @(posedge clock);
        accepted = s_valid && s_ready;
        check_value("single beat accepted", 32'(accepted), 32'd1);
        s_valid <= 1'b0;

        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < 10) begin
            @(posedge clock);
            cycles++;
            seen = m_valid;
        end
        if (!seen) begin
            $display("no output appeared within 10 cycles after the single beat");
            errors++;
        end else begin
            check_value("single beat latency", 32'(cycles), 32'd3);
        end

        // random traffic with random back-pressure
        sent = 0;
        while (sent < num_beats) begin
            @(posedge clock);
            if (s_valid && s_ready)
                sent++;
            m_ready <= ($random(seed) & 3) != 0;
            // a pending beat holds until it transfers
            if (!s_valid || s_ready) begin
                if (sent < num_beats && ($random(seed) & 3) != 0) begin
                    s_valid <= 1'b1;
                    s_beat <= random_beat();
                    weights <= random_weights();
                end else begin
                    s_valid <= 1'b0;
                end
            end
        end

        // drain what is still in flight
        while (beats_out < total_beats) begin
            @(posedge clock);
            m_ready <= ($random(seed) & 3) != 0;
        end
        repeat (5) @(posedge clock);

        check_value("beats delivered", 32'(beats_out), 32'(total_beats));
        check_value("beats left in model", 32'(exp_data.size()), 32'd0);

        $display("errors: %0d, beats in: %0d, beats out: %0d", errors, beats_in, beats_out);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    // watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clock);
        $display("simulation timed out after %0d cycles, %0d of %0d beats delivered, errors: %0d",
                 timeout_cycles, beats_out, total_beats, errors);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== beam_former.f ====
common/beam_pkg.sv
hw/beam_ingress.sv
hw/channel_weighting/channel_weighting.sv
hw/combiner/beam_combiner.sv
hw/beam_former.sv
sim/beam_former_props.sv
sim/beam_former_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the beam_former testbench with Verilator and runs it

cd "$(dirname "$0")" || {
    echo "cannot enter the project directory"
    exit 1
}

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    -f beam_former.f \
    --top-module beam_former_tb \
    -o beam_former_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/beam_former_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test completed successfully" <<< "$output"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
